//--- alu32_core.f
+incdir+include
verilog/alu32_pkg.sv
verilog/alu32.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/load_store_unit.sv
verilog/mem_arbiter.sv
verilog/unified_memory.sv
verilog/core_control.sv
verilog/alu32_core.sv
verification/alu32_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the alu32_core testbench with Verilator and runs it from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f alu32_core.f \
  --top-module alu32_core_tb \
  -o alu32_core_sim

./obj_dir/alu32_core_sim | tee "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
echo "simulation passed"

//--- verification/alu32_cases.txt
// header: number of preload data words, number of instruction records
// data lines: word address, data word
// record lines: pc, instruction word, expected rd, value, overflow, store
// all fields are hex, records retire in file order and the last one is HALT
02 17
80 CAFEF00D
81 13579BDF
00 441FFFFB 01 FFFFFFFB 0 0
01 442FFFFF 02 FFFFFFFF 0 0
02 40210409 02 7FFFFFFF 0 0
03 50310001 03 80000000 1 0
04 50407FFD 04 FFFFFFFD 0 0
05 44512345 05 00012345 0 0
06 4460F0F0 06 0000F0F0 0 0
07 40729800 07 00021435 0 0
08 40819401 08 7FFEDCBB 1 0
09 40929802 09 00002040 0 0
0A 40A29804 0A 0001F3F5 0 0
0B 40B08803 0B 80000004 0 0
0C 40C29008 0C 00123450 0 0
0D 40D0F009 0D 0000000F 0 0
0E 40E28009 0E 00000000 0 0
0F 40F2A00B 0F 45000123 0 0
10 59007ABC 10 00007ABC 0 0
11 5710C001 11 FFFFBFFA 0 0
12 14700040 07 00021435 0 1
13 05200040 12 00021435 0 0
14 05337F90 13 CAFEF00D 0 0
15 05400081 14 13579BDF 0 0
16 7E000000 00 00000000 0 0

//--- include/alu32_core_tb_tasks.svh
`ifndef ALU32_CORE_TB_TASKS_SVH
`define ALU32_CORE_TB_TASKS_SVH

int error_count = 0;
int check_count = 0;

task automatic compare_word(input word_t got, input word_t exp, input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL at %0d ns: %s expected %h, got %h", $time, what, exp, got);
  end
endtask

task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL at %0d ns: %s expected %0d, got %0d", $time, what, exp, got);
  end
endtask

task automatic compare_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL at %0d ns: %s expected r%0d, got r%0d", $time, what, exp, got);
  end
endtask

// overflow, store and halted flags
task automatic compare_bit(input logic got, input logic exp, input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL at %0d ns: %s expected %b, got %b", $time, what, exp, got);
  end
endtask

`endif

//--- verification/alu32_core_tb.sv
`timescale 1ns/1ps

module alu32_core_tb;
  import alu32_pkg::*;

  localparam int CLK_HALF   = 10;
  localparam int RESET_CYC  = 16;
  localparam int CASE_WORDS = 256;
  localparam int REC_WORDS  = 6;
  localparam int TAIL_CYC   = 20;

  logic     clk;
  logic     reset;
  logic     run;
  logic     load_valid;
  addr_t    load_addr;
  word_t    load_data;
  logic     halted;
  logic     retire_valid;
  addr_t    retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_value;
  logic     retire_overflow;
  logic     retire_store;

  word_t    cases [CASE_WORDS];
  int       num_data;
  int       num_recs;
  int       rec_base;
  int       retire_count;
  int       test_count;
  int       test_fail;
  int       watchdog_cycles;
  int       seed;
  logic     cases_ready;

  `include "alu32_core_tb_tasks.svh"

  alu32_core i_dut (
    .clk             (clk),
    .reset           (reset),
    .run             (run),
    .load_valid      (load_valid),
    .load_addr       (load_addr),
    .load_data       (load_data),
    .halted          (halted),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_rd       (retire_rd),
    .retire_value    (retire_value),
    .retire_overflow (retire_overflow),
    .retire_store    (retire_store)
  );

  always #CLK_HALF clk = ~clk;

  // **********************************************************************
  // loader and retire checking
  // **********************************************************************
  task automatic load_word(input addr_t addr, input word_t data);
    int gap;
    @(negedge clk);
    load_valid = 1'b1;
    load_addr  = addr;
    load_data  = data;
    @(negedge clk);
    load_valid = 1'b0;
    gap = $random(seed) & 3;
    repeat (gap) @(negedge clk);
  endtask

  task automatic check_retire(input int idx);
    int base;
    int fails_before;
    base = rec_base + REC_WORDS * idx;
    fails_before = error_count;
    compare_addr(retire_pc, addr_t'(cases[base]), "retire pc");
    compare_idx(retire_rd, reg_idx_t'(cases[base + 2]), "retire rd");
    compare_word(retire_value, cases[base + 3], "retire value");
    compare_bit(retire_overflow, cases[base + 4][0], "retire overflow");
    compare_bit(retire_store, cases[base + 5][0], "retire store");
    test_count++;
    if (error_count != fails_before) begin
      test_fail++;
    end
    $display("test %0d pc %0d instr %h: %s", idx, cases[base][ADDR_W-1:0], cases[base + 1],
             (error_count == fails_before) ? "ok" : "mismatch");
  endtask

  task automatic run_program();
    int idx;
    int fails_before;
    for (idx = 0; idx < num_data; idx++) begin
      load_word(addr_t'(cases[2 + 2 * idx]), cases[3 + 2 * idx]);
    end
    // every instruction goes to its own pc
    for (idx = 0; idx < num_recs; idx++) begin
      load_word(addr_t'(cases[rec_base + REC_WORDS * idx]),
                cases[rec_base + REC_WORDS * idx + 1]);
    end
    @(negedge clk);
    run = 1'b1;
    while (!halted) begin
      @(negedge clk);
      if (retire_valid) begin
        if (retire_count < num_recs) begin
          check_retire(retire_count);
        end else begin
          error_count++;
          $display("unexpected retire at pc %0d beyond the expected records", retire_pc);
        end
        retire_count++;
      end
    end
    // after HALT the core must stay quiet
    fails_before = error_count;
    repeat (TAIL_CYC) begin
      @(negedge clk);
      compare_bit(halted, 1'b1, "halted held");
      if (retire_valid) begin
        error_count++;
        $display("retire at pc %0d after the core halted", retire_pc);
      end
    end
    if (retire_count != num_recs) begin
      error_count++;
      $display("FAIL at %0d ns: %0d retires, expected %0d", $time, retire_count, num_recs);
    end
    test_count++;
    if (error_count != fails_before) begin
      test_fail++;
    end
    $display("test halt: %0d retires, halted %b: %s", retire_count, halted,
             (error_count == fails_before) ? "ok" : "mismatch");
  endtask

  // **********************************************************************
  // main sequence and watchdog
  // **********************************************************************
  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    run             = 1'b0;
    load_valid      = 1'b0;
    load_addr       = '0;
    load_data       = '0;
    seed            = 59;
    retire_count    = 0;
    test_count      = 0;
    test_fail       = 0;
    watchdog_cycles = 0;
    cases_ready     = 1'b0;
    $readmemh("verification/alu32_cases.txt", cases);
    num_data = int'(cases[0]);
    num_recs = int'(cases[1]);
    rec_base = 2 + 2 * num_data;
    repeat (RESET_CYC) @(negedge clk);
    reset = 1'b0;
    if ($isunknown({cases[0], cases[1]}) || (num_recs == 0)) begin
      error_count++;
      $display("cases file missing or empty, nothing to run");
    end else begin
      // a loader write takes two cycles plus up to 3 idle cycles
      watchdog_cycles = (num_data + num_recs) * 5 + num_recs * 64 + TAIL_CYC + 8;
      cases_ready = 1'b1;
      run_program();
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_count, test_fail, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    wait (cases_ready);
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the core did not halt", watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- verilog/alu32_core.sv
`timescale 1ns/1ps

module alu32_core (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic                load_valid,
  input  alu32_pkg::addr_t    load_addr,
  input  alu32_pkg::word_t    load_data,
  output logic                halted,
  output logic                retire_valid,
  output alu32_pkg::addr_t    retire_pc,
  output alu32_pkg::reg_idx_t retire_rd,
  output alu32_pkg::word_t    retire_value,
  output logic                retire_overflow,
  output logic                retire_store
);
  import alu32_pkg::*;

  // ********************************************************************
  // memory side
  // ********************************************************************
  logic     ram_en;
  logic     ram_we;
  addr_t    ram_addr;
  word_t    ram_wdata;
  word_t    ram_rdata;
  word_t    shared_rdata;
  logic     fetch_req;
  addr_t    fetch_addr;
  logic     fetch_ack;
  logic     lsu_req;
  logic     lsu_we;
  addr_t    lsu_addr;
  word_t    lsu_wdata;
  logic     lsu_ack;

  // core side
  logic     fetch_start;
  logic     fetch_done;
  word_t    instr;
  addr_t    pc;
  logic     lsu_start;
  logic     lsu_done;
  logic     is_store;
  addr_t    ctrl_mem_addr;
  word_t    store_data;
  word_t    lsu_load_data;
  logic     enable_execute;
  opcode_t  opcode;
  sub_op_t  sub_opcode_5bit;
  word_t    scr1;
  word_t    scr2;
  word_t    alu_result;
  logic     alu_overflow;
  reg_idx_t ra_idx;
  reg_idx_t rb_idx;
  reg_idx_t wr_idx;
  logic     wr_en;
  word_t    wr_data;
  word_t    ra_data;
  word_t    rb_data;

  unified_memory i_memory (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  // the loader port writes without waiting for its ack
  mem_arbiter i_arbiter (
    .clk          (clk),
    .reset        (reset),
    .loader_req   (load_valid),
    .loader_addr  (load_addr),
    .loader_wdata (load_data),
    .lsu_req      (lsu_req),
    .lsu_we       (lsu_we),
    .lsu_addr     (lsu_addr),
    .lsu_wdata    (lsu_wdata),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .mem_rdata    (ram_rdata),
    .mem_en       (ram_en),
    .mem_we       (ram_we),
    .mem_addr     (ram_addr),
    .mem_wdata    (ram_wdata),
    .loader_ack   (),
    .lsu_ack      (lsu_ack),
    .fetch_ack    (fetch_ack),
    .shared_rdata (shared_rdata)
  );

  fetch_unit i_fetch (
    .clk         (clk),
    .reset       (reset),
    .fetch_start (fetch_start),
    .ack         (fetch_ack),
    .rdata       (shared_rdata),
    .req         (fetch_req),
    .addr        (fetch_addr),
    .instr       (instr),
    .pc          (pc),
    .fetch_done  (fetch_done)
  );

  load_store_unit i_lsu (
    .clk        (clk),
    .reset      (reset),
    .lsu_start  (lsu_start),
    .is_store   (is_store),
    .mem_addr   (ctrl_mem_addr),
    .store_data (store_data),
    .ack        (lsu_ack),
    .rdata      (shared_rdata),
    .req        (lsu_req),
    .we         (lsu_we),
    .addr       (lsu_addr),
    .wdata      (lsu_wdata),
    .load_data  (lsu_load_data),
    .lsu_done   (lsu_done)
  );

  register_file i_regs (
    .clk     (clk),
    .reset   (reset),
    .ra_idx  (ra_idx),
    .rb_idx  (rb_idx),
    .wr_idx  (wr_idx),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .ra_data (ra_data),
    .rb_data (rb_data)
  );

  alu32 i_alu (
    .enable_execute  (enable_execute),
    .opcode          (opcode),
    .sub_opcode_5bit (sub_opcode_5bit),
    .scr1            (scr1),
    .scr2            (scr2),
    .alu_result      (alu_result),
    .alu_overflow    (alu_overflow)
  );

  core_control i_control (
    .clk             (clk),
    .reset           (reset),
    .run             (run),
    .instr           (instr),
    .ra_data         (ra_data),
    .rb_data         (rb_data),
    .alu_result      (alu_result),
    .alu_overflow    (alu_overflow),
    .load_data       (lsu_load_data),
    .fetch_done      (fetch_done),
    .lsu_done        (lsu_done),
    .pc              (pc),
    .fetch_start     (fetch_start),
    .lsu_start       (lsu_start),
    .is_store        (is_store),
    .mem_addr        (ctrl_mem_addr),
    .store_data      (store_data),
    .enable_execute  (enable_execute),
    .opcode          (opcode),
    .sub_opcode_5bit (sub_opcode_5bit),
    .scr1            (scr1),
    .scr2            (scr2),
    .ra_idx          (ra_idx),
    .rb_idx          (rb_idx),
    .wr_idx          (wr_idx),
    .wr_en           (wr_en),
    .wr_data         (wr_data),
    .halted          (halted),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_rd       (retire_rd),
    .retire_value    (retire_value),
    .retire_overflow (retire_overflow),
    .retire_store    (retire_store)
  );

endmodule

//--- verilog/core_control.sv
`timescale 1ns/1ps

module core_control (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  alu32_pkg::word_t    instr,
  input  alu32_pkg::word_t    ra_data,
  input  alu32_pkg::word_t    rb_data,
  input  alu32_pkg::word_t    alu_result,
  input  logic                alu_overflow,
  input  alu32_pkg::word_t    load_data,
  input  logic                fetch_done,
  input  logic                lsu_done,
  input  alu32_pkg::addr_t    pc,
  output logic                fetch_start,
  output logic                lsu_start,
  output logic                is_store,
  output alu32_pkg::addr_t    mem_addr,
  output alu32_pkg::word_t    store_data,
  output logic                enable_execute,
  output alu32_pkg::opcode_t  opcode,
  output alu32_pkg::sub_op_t  sub_opcode_5bit,
  output alu32_pkg::word_t    scr1,
  output alu32_pkg::word_t    scr2,
  output alu32_pkg::reg_idx_t ra_idx,
  output alu32_pkg::reg_idx_t rb_idx,
  output alu32_pkg::reg_idx_t wr_idx,
  output logic                wr_en,
  output alu32_pkg::word_t    wr_data,
  output logic                halted,
  output logic                retire_valid,
  output alu32_pkg::addr_t    retire_pc,
  output alu32_pkg::reg_idx_t retire_rd,
  output alu32_pkg::word_t    retire_value,
  output logic                retire_overflow,
  output logic                retire_store
);
  import alu32_pkg::*;

  ctrl_state_t state;
  addr_t       cur_pc;
  word_t       alu_q;
  logic        ovf_q;
  word_t       imm15_s;
  logic        is_load;
  logic        is_halt;
  logic        is_shift;

  // ********************************************************************
  // decode
  // ********************************************************************
  assign opcode          = instr[OPC_MSB:OPC_LSB];
  assign sub_opcode_5bit = instr[SUB_MSB:SUB_LSB];
  assign ra_idx          = instr[RA_MSB:RA_LSB];
  assign wr_idx          = instr[RT_MSB:RT_LSB];
  assign is_store        = (opcode == SWI);
  assign is_load         = (opcode == LWI);
  assign is_halt         = (opcode == HALT);
  assign is_shift        = (opcode == TYPE_BASIC) && ((sub_opcode_5bit == SRLI) ||
                           (sub_opcode_5bit == SLLI) || (sub_opcode_5bit == ROTRI));

  // the store source sits in rt, so the second read port follows it for SWI
  assign rb_idx  = is_store ? wr_idx : instr[RB_MSB:RB_LSB];
  assign imm15_s = {{(31 - IMM15_MSB){instr[IMM15_MSB]}}, instr[IMM15_MSB:0]};

  assign scr1 = ra_data;
  always_comb begin
    case (opcode)
      TYPE_BASIC: scr2 = is_shift ? {27'b0, instr[RB_MSB:RB_LSB]} : rb_data;
      ADDI:       scr2 = imm15_s;
      ORI, XORI:  scr2 = {{(31 - IMM15_MSB){1'b0}}, instr[IMM15_MSB:0]};
      MOVI:       scr2 = {{(31 - IMM20_MSB){instr[IMM20_MSB]}}, instr[IMM20_MSB:0]};
      default:    scr2 = '0;
    endcase
  end

  assign mem_addr   = ra_data[ADDR_W-1:0] + imm15_s[ADDR_W-1:0];
  assign store_data = rb_data;

  // ********************************************************************
  // step sequencing
  // ********************************************************************
  assign enable_execute = (state == ST_EXEC);
  assign fetch_start    = run && ((state == ST_IDLE) || ((state == ST_WB) && !is_halt));
  assign lsu_start      = (state == ST_EXEC) && (is_load || is_store);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  state <= run ? ST_FETCH : ST_IDLE;
        ST_FETCH: state <= fetch_done ? ST_EXEC : ST_FETCH;
        ST_EXEC:  state <= (is_load || is_store) ? ST_MEM : ST_WB;
        ST_MEM:   state <= lsu_done ? ST_WB : ST_MEM;
        ST_WB: begin
          if (is_halt) begin
            state <= ST_HALT;
          end else begin
            state <= run ? ST_FETCH : ST_IDLE;
          end
        end
        default:  state <= ST_HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_start) begin
      cur_pc <= pc;
    end
    if (enable_execute) begin
      alu_q <= alu_result;
      ovf_q <= alu_overflow;
    end
  end

  // write-back and retire
  assign wr_data         = is_load ? load_data : alu_q;
  assign wr_en           = (state == ST_WB) && !is_store && !is_halt;
  assign retire_valid    = (state == ST_WB);
  assign retire_pc       = cur_pc;
  assign retire_rd       = wr_idx;
  assign retire_value    = is_store ? store_data : wr_data;
  assign retire_overflow = ovf_q;
  assign retire_store    = is_store;
  assign halted          = (state == ST_HALT);

endmodule

//--- verilog/unified_memory.sv
`timescale 1ns/1ps

module unified_memory (
  input  logic             clk,
  input  logic             en,
  input  logic             we,
  input  alu32_pkg::addr_t addr,
  input  alu32_pkg::word_t wdata,
  output alu32_pkg::word_t rdata
);
  import alu32_pkg::*;

  word_t mem [MEM_WORDS];

  // read before write, so a write returns the word it replaced
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[addr];
      if (we) begin
        mem[addr] <= wdata;
      end
    end
  end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic             clk,
  input  logic             reset,
  input  logic             loader_req,
  input  alu32_pkg::addr_t loader_addr,
  input  alu32_pkg::word_t loader_wdata,
  input  logic             lsu_req,
  input  logic             lsu_we,
  input  alu32_pkg::addr_t lsu_addr,
  input  alu32_pkg::word_t lsu_wdata,
  input  logic             fetch_req,
  input  alu32_pkg::addr_t fetch_addr,
  input  alu32_pkg::word_t mem_rdata,
  output logic             mem_en,
  output logic             mem_we,
  output alu32_pkg::addr_t mem_addr,
  output alu32_pkg::word_t mem_wdata,
  output logic             loader_ack,
  output logic             lsu_ack,
  output logic             fetch_ack,
  output alu32_pkg::word_t shared_rdata
);

  logic gnt_loader;
  logic gnt_lsu;
  logic gnt_fetch;

  // a requester still shows its request in its ack cycle and must not be granted again
  assign gnt_loader = loader_req;
  assign gnt_lsu    = lsu_req && !lsu_ack && !gnt_loader;
  assign gnt_fetch  = fetch_req && !fetch_ack && !gnt_loader && !gnt_lsu;

  assign mem_en    = gnt_loader || gnt_lsu || gnt_fetch;
  assign mem_we    = gnt_loader || (gnt_lsu && lsu_we);
  assign mem_addr  = gnt_loader ? loader_addr : (gnt_lsu ? lsu_addr : fetch_addr);
  assign mem_wdata = gnt_loader ? loader_wdata : lsu_wdata;

  // the grant is registered and comes back as the ack, next to the read data
  always_ff @(posedge clk) begin
    if (reset) begin
      loader_ack <= 1'b0;
      lsu_ack    <= 1'b0;
      fetch_ack  <= 1'b0;
    end else begin
      loader_ack <= gnt_loader;
      lsu_ack    <= gnt_lsu;
      fetch_ack  <= gnt_fetch;
    end
  end

  assign shared_rdata = mem_rdata;

  // the core requesters keep their request up through the cycle of their ack
  a_ack_with_req: assert property (@(posedge clk) disable iff (reset)
    (!lsu_ack || lsu_req) && (!fetch_ack || fetch_req))
    else $error("mem_arbiter: ack arrived after the request was dropped");

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             lsu_start,
  input  logic             is_store,
  input  alu32_pkg::addr_t mem_addr,
  input  alu32_pkg::word_t store_data,
  input  logic             ack,
  input  alu32_pkg::word_t rdata,
  output logic             req,
  output logic             we,
  output alu32_pkg::addr_t addr,
  output alu32_pkg::word_t wdata,
  output alu32_pkg::word_t load_data,
  output logic             lsu_done
);

  always_ff @(posedge clk) begin
    if (reset) begin
      req <= 1'b0;
      we  <= 1'b0;
    end else if (lsu_start) begin
      req <= 1'b1;
      we  <= is_store;
    end else if (req && ack) begin
      req <= 1'b0;
      we  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_start) begin
      addr  <= mem_addr;
      wdata <= store_data;
    end
    // a store reads the old word back, which is of no use to the core
    if (req && ack && !we) begin
      load_data <= rdata;
    end
  end

  assign lsu_done = req && ack;

  a_addr_stable: assert property (@(posedge clk) disable iff (reset)
    (req && !ack) |=> $stable(addr))
    else $error("load_store_unit: address changed while waiting for ack");

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             fetch_start,
  input  logic             ack,
  input  alu32_pkg::word_t rdata,
  output logic             req,
  output alu32_pkg::addr_t addr,
  output alu32_pkg::word_t instr,
  output alu32_pkg::addr_t pc,
  output logic             fetch_done
);

  always_ff @(posedge clk) begin
    if (reset) begin
      req <= 1'b0;
      pc  <= '0;
    end else if (fetch_start) begin
      req <= 1'b1;
    end else if (req && ack) begin
      req <= 1'b0;
      pc  <= pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req && ack) begin
      instr <= rdata;
    end
  end

  // pc only moves on the ack edge, so the address holds for the whole request
  assign addr       = pc;
  assign fetch_done = req && ack;

  a_req_until_ack: assert property (@(posedge clk) disable iff (reset)
    (req && !ack) |=> req)
    else $error("fetch_unit: request dropped before ack");

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                clk,
  input  logic                reset,
  input  alu32_pkg::reg_idx_t ra_idx,
  input  alu32_pkg::reg_idx_t rb_idx,
  input  alu32_pkg::reg_idx_t wr_idx,
  input  logic                wr_en,
  input  alu32_pkg::word_t    wr_data,
  output alu32_pkg::word_t    ra_data,
  output alu32_pkg::word_t    rb_data
);
  import alu32_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // reads see the old value in a write cycle
  assign ra_data = regs[ra_idx];
  assign rb_data = regs[rb_idx];

endmodule

//--- verilog/alu32.sv
`timescale 1ns/1ps

module alu32 (
  input  logic               enable_execute,
  input  alu32_pkg::opcode_t opcode,
  input  alu32_pkg::sub_op_t sub_opcode_5bit,
  input  alu32_pkg::word_t   scr1,
  input  alu32_pkg::word_t   scr2,
  output alu32_pkg::word_t   alu_result,
  output logic               alu_overflow
);
  import alu32_pkg::*;

  word_t       sum;
  word_t       diff;
  logic        add_ovf;
  logic        sub_ovf;
  logic [4:0]  shamt;
  logic [63:0] rot;

  assign sum   = scr1 + scr2;
  assign diff  = scr1 - scr2;
  assign shamt = scr2[4:0];
  assign rot   = {scr1, scr1} >> shamt;

  // signed overflow when the operands agree in sign (add) or differ (sub) and the result flips
  assign add_ovf = (scr1[31] == scr2[31]) && (sum[31] != scr1[31]);
  assign sub_ovf = (scr1[31] != scr2[31]) && (diff[31] != scr1[31]);

  always_comb begin
    alu_result   = '0;
    alu_overflow = 1'b0;
    if (enable_execute) begin
      case (opcode)
        TYPE_BASIC: begin
          case (sub_opcode_5bit)
            ADD: begin
              alu_result   = sum;
              alu_overflow = add_ovf;
            end
            SUB: begin
              alu_result   = diff;
              alu_overflow = sub_ovf;
            end
            AND_OP: alu_result = scr1 & scr2;
            OR_OP:  alu_result = scr1 | scr2;
            XOR_OP: alu_result = scr1 ^ scr2;
            // a zero shift amount gives zero here, not the operand
            SRLI:   alu_result = (shamt != 5'd0) ? (scr1 >> shamt) : '0;
            SLLI:   alu_result = scr1 << shamt;
            ROTRI:  alu_result = rot[31:0];
            default: alu_result = '0;
          endcase
        end
        ADDI: begin
          alu_result   = sum;
          alu_overflow = add_ovf;
        end
        ORI:     alu_result = scr1 | scr2;
        XORI:    alu_result = scr1 ^ scr2;
        MOVI:    alu_result = scr2;
        default: alu_result = '0;
      endcase
    end
  end

  // operands come from the register file and the immediate decode
  always_comb begin
    if (enable_execute) begin
      assert (!$isunknown({alu_result, alu_overflow}))
        else $error("alu32: unknown output for opcode %b", opcode);
    end
  end

endmodule

//--- verilog/alu32_pkg.sv
package alu32_pkg;

  // ********************************************************************
  // widths and storage sizes
  // ********************************************************************
  localparam int ADDR_W    = 8;
  localparam int MEM_WORDS = 2 ** ADDR_W;
  localparam int NUM_REGS  = 32;

  typedef logic [31:0]       word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [4:0]        reg_idx_t;
  typedef logic [5:0]        opcode_t;
  typedef logic [4:0]        sub_op_t;

  // major opcodes
  localparam opcode_t TYPE_BASIC = 6'b100000;
  localparam opcode_t ADDI       = 6'b101000;
  localparam opcode_t ORI        = 6'b101100;
  localparam opcode_t XORI       = 6'b101011;
  localparam opcode_t MOVI       = 6'b100010;
  localparam opcode_t LWI        = 6'b000010;
  localparam opcode_t SWI        = 6'b001010;
  localparam opcode_t HALT       = 6'b111111;

  // sub-opcodes of the basic type
  localparam sub_op_t ADD    = 5'b00000;
  localparam sub_op_t SUB    = 5'b00001;
  localparam sub_op_t AND_OP = 5'b00010;
  localparam sub_op_t OR_OP  = 5'b00100;
  localparam sub_op_t XOR_OP = 5'b00011;
  localparam sub_op_t SRLI   = 5'b01001;
  localparam sub_op_t SLLI   = 5'b01000;
  localparam sub_op_t ROTRI  = 5'b01011;

  // ********************************************************************
  // instruction field positions
  // ********************************************************************
  localparam int OPC_MSB   = 30;
  localparam int OPC_LSB   = 25;
  localparam int RT_MSB    = 24;
  localparam int RT_LSB    = 20;
  localparam int RA_MSB    = 19;
  localparam int RA_LSB    = 15;
  localparam int RB_MSB    = 14;
  localparam int RB_LSB    = 10;
  localparam int SUB_MSB   = 4;
  localparam int SUB_LSB   = 0;
  localparam int IMM15_MSB = 14;
  localparam int IMM20_MSB = 19;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_WB,
    ST_HALT
  } ctrl_state_t;

endpackage
